/* bench/systolic_array_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module systolic_array_tb
    import sysarr_num_pkg::*;
    import sysarr_ctrl_pkg::*;
();

    localparam int N = 4;
    localparam int IW = idx_w(N);
    localparam int NUM_JOBS = 8;
    // one full output row is the widest value compared
    localparam int CHK_W = N * WORD_W;
    // allowance per job for vectors, weight rows, compute and drain
    // plus a fixed margin
    localparam int TIMEOUT_CYCLES = NUM_JOBS * (6 * N + 4 * (3 * N)) + 100;

    // host vector with word 0 at the top index
    typedef word_t [N-1:0] vec_t;

    logic clk;
    logic nRST;
    logic weight_en;
    logic input_en;
    logic partial_en;
    logic row_in_en;
    logic row_ps_en;
    vec_t array_in;
    vec_t array_in_partials;
    logic fifo_has_space;
    logic drained;
    logic out_en;
    logic [IW-1:0] row_out;
    vec_t array_output;

    integer seed = 32'h013b_923f;
    string test_name = "reset";

    // reference matrices and expected rows
    `include "include/sysarr_tb_model.svh"

    // rows still owed by the DUT in arrival order
    vec_t exp_rows [$];
    int exp_idx [$];

    systolic_array #(.N(N)) uut (
        .clk               (clk),
        .nRST              (nRST),
        .weight_en         (weight_en),
        .input_en          (input_en),
        .partial_en        (partial_en),
        .row_in_en         (row_in_en),
        .row_ps_en         (row_ps_en),
        .array_in          (array_in),
        .array_in_partials (array_in_partials),
        .fifo_has_space    (fifo_has_space),
        .drained           (drained),
        .out_en            (out_en),
        .row_out           (row_out),
        .array_output      (array_output)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [CHK_W-1:0] expected,
                               input logic [CHK_W-1:0] actual);
        if (expected !== actual) begin
            fail_now($sformatf("error: %s: %s expected %0h actual %0h",
                               test_name, what, expected, actual));
        end
    endtask

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    function automatic vec_t rand_vec();
        vec_t v;
        for (int i = 0; i < N; i++) begin
            v[i] = rand_word();
        end
        return v;
    endfunction

    // one cycle of host inputs
    // returns at the following falling edge
    task automatic drive(input logic w_en, input logic i_en, input logic p_en,
                         input logic in_stb, input logic ps_stb,
                         input vec_t vin, input vec_t vps);
        @(posedge clk);
        weight_en         <= w_en;
        input_en          <= i_en;
        partial_en        <= p_en;
        row_in_en         <= in_stb;
        row_ps_en         <= ps_stb;
        array_in          <= vin;
        array_in_partials <= vps;
        @(negedge clk);
    endtask

    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        end
    endtask

    // 0..3 idle cycles
    task automatic random_gap();
        idle_gap($unsigned($random(seed)) % 4);
    endtask

    // fresh W loaded in row order 0..N-1
    task automatic load_weights();
        gen_weights(seed);
        for (int m = 0; m < N; m++) begin
            random_gap();
            drive(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, weight_row(m), rand_vec());
        end
        idle_gap(1);
    endtask

    task automatic run_job(input bit busy);
        int ni;
        int pi;
        int sent;
        bit pick_in;
        logic [4:0] junk;
        gen_job(seed);
        for (int r = 0; r < N; r++) begin
            exp_rows.push_back(expected_row(r));
            exp_idx.push_back(r);
        end
        check_value("fifo_has_space before job", 1, CHK_W'(fifo_has_space));
        check_value("drained before job", 1, CHK_W'(drained));
        ni = 0;
        pi = 0;
        sent = 0;
        // inputs and partials in random order
        while (ni < N || pi < N) begin
            random_gap();
            pick_in = (pi == N) || ((ni < N) && ($random(seed) % 2 != 0));
            if (pick_in) begin
                drive(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, input_vec(ni), rand_vec());
                ni++;
            end else begin
                drive(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, rand_vec(), partial_vec(pi));
                pi++;
            end
            sent++;
            // first vector taken by now
            if (sent == 2) begin
                check_value("drained after first vector", 0, CHK_W'(drained));
                check_value("fifo_has_space while loading", 1, CHK_W'(fifo_has_space));
            end
        end
        // last vector sampled on this edge
        idle_gap(1);
        check_value("fifo_has_space after last vector", 0, CHK_W'(fifo_has_space));
        check_value("drained during compute", 0, CHK_W'(drained));
        while (!fifo_has_space) begin
            // junk only while it still lands before the load phase returns
            if (busy && !(out_en && row_out == IW'(N - 1))) begin
                junk = 5'($random(seed));
                drive(junk[0], junk[1], junk[2], junk[3], junk[4], rand_vec(), rand_vec());
            end else begin
                idle_gap(1);
            end
        end
        check_value("drained after last row", 1, CHK_W'(drained));
        check_value("rows still owed", 0, CHK_W'(exp_rows.size()));
    endtask

    // output monitor samples at the falling edge where outputs are stable
    always @(negedge clk) begin
        if (nRST && out_en) begin
            if (fifo_has_space) begin
                fail_now("out_en was high while fifo_has_space was also high");
            end else if (exp_rows.size() == 0) begin
                fail_now("an output row appeared with no job in flight");
            end else begin
                check_value("row_out", CHK_W'(exp_idx[0]), CHK_W'(row_out));
                check_value($sformatf("array_output row %0d", exp_idx[0]),
                            exp_rows[0], array_output);
                void'(exp_rows.pop_front());
                void'(exp_idx.pop_front());
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_now($sformatf("watchdog ran out after %0d cycles, the DUT stopped making progress",
                           TIMEOUT_CYCLES));
    end

    initial begin
        nRST              = 1'b0;
        weight_en         = 1'b0;
        input_en          = 1'b0;
        partial_en        = 1'b0;
        row_in_en         = 1'b0;
        row_ps_en         = 1'b0;
        array_in          = '0;
        array_in_partials = '0;
        repeat (5) @(posedge clk);
        nRST <= 1'b1;
        // idle flags and cleared results
        repeat (4) begin
            @(negedge clk);
            check_value("fifo_has_space", 1, CHK_W'(fifo_has_space));
            check_value("drained", 1, CHK_W'(drained));
            check_value("out_en", 0, CHK_W'(out_en));
            check_value("array_output", 0, array_output);
        end
        for (int j = 0; j < NUM_JOBS; j++) begin
            if (j == 0) begin
                test_name = "single job";
            end else if (j < 3) begin
                test_name = "weight reuse";
            end else if (j % 2 == 0) begin
                test_name = "reload and flags";
            end else begin
                test_name = "busy strobes";
            end
            // reload on the first job and on every even one after the reuse runs
            if (j == 0 || (j >= 4 && j % 2 == 0)) begin
                load_weights();
            end
            run_job(j >= 3);
            random_gap();
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/sysarr_control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// host strobe decode, job phases and the skewed grid schedule
module sysarr_control_unit
    import sysarr_ctrl_pkg::*;
#(
    parameter int N = 4
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 weight_en,
    input  logic                 input_en,
    input  logic                 partial_en,
    input  logic                 row_in_en,
    input  logic                 row_ps_en,
    output logic                 fifo_has_space,
    output logic                 drained,
    output logic [N-1:0]         weight_load,
    output logic [N-1:0]         input_load,
    output logic [N-1:0]         partials_load,
    output logic [N-1:0]         in_fifo_shift,
    output logic [N-1:0]         ps_fifo_shift,
    output logic                 mac_enable,
    output logic [N-1:0]         capture,
    output logic                 out_en,
    output logic [idx_w(N)-1:0]  row_out
);

    localparam int IW = idx_w(N);
    localparam int CW = idx_w(N + 1);
    localparam int SW = step_w(N);
    localparam logic [IW-1:0] W_ROW_LAST = IW'(N - 1);
    localparam logic [CW-1:0] CNT_FULL = CW'(N);
    localparam logic [CW-1:0] CNT_LAST = CW'(N - 1);
    localparam logic [SW-1:0] STEP_LAST = SW'(3 * N - 2);
    localparam logic [SW-1:0] ROW_LAST = SW'(N - 1);

    phase_t phase;
    logic [IW-1:0] w_row;
    logic [CW-1:0] in_cnt;
    logic [CW-1:0] ps_cnt;
    logic [SW-1:0] step;
    logic w_take;
    logic in_take;
    logic ps_take;
    logic in_done;
    logic ps_done;

    assign fifo_has_space = (phase == PH_LOAD);
    assign mac_enable     = (phase == PH_COMPUTE);
    assign out_en         = (phase == PH_OUTPUT);
    // output row rides on the step counter
    assign row_out        = step[IW-1:0];

    // accepted strobes, weight wins over input on array_in
    assign w_take  = fifo_has_space && row_in_en && weight_en;
    assign in_take = fifo_has_space && row_in_en && input_en && !weight_en &&
                     (in_cnt != CNT_FULL);
    assign ps_take = fifo_has_space && row_ps_en && partial_en && (ps_cnt != CNT_FULL);

    // all vectors in, counting the one taken this cycle
    assign in_done = (in_cnt == CNT_FULL) || (in_take && in_cnt == CNT_LAST);
    assign ps_done = (ps_cnt == CNT_FULL) || (ps_take && ps_cnt == CNT_LAST);

    // one-hot row loads from the counters
    always_comb begin
        for (int i = 0; i < N; i++) begin
            weight_load[i]   = w_take && (w_row == IW'(i));
            input_load[i]    = in_take && (in_cnt == CW'(i));
            partials_load[i] = ps_take && (ps_cnt == CW'(i));
        end
    end

    // input fifo i shifts on steps i..i+N-1
    // column i sums leave the grid on steps N+i..2N+i-1
    always_comb begin
        for (int i = 0; i < N; i++) begin
            in_fifo_shift[i] = mac_enable && (step >= SW'(i)) && (step < SW'(i + N));
            capture[i]       = mac_enable && (step >= SW'(i + N)) &&
                               (step < SW'(i + 2 * N));
        end
    end

    // partial word r is consumed with the sum of row r
    assign ps_fifo_shift = capture;

    // weight rows wrap back to row 0
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            w_row <= '0;
        end else if (w_take) begin
            w_row <= (w_row == W_ROW_LAST) ? '0 : w_row + 1'b1;
        end
    end

    // job phase sequencing
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            phase   <= PH_LOAD;
            step    <= '0;
            in_cnt  <= '0;
            ps_cnt  <= '0;
            drained <= 1'b1;
        end else begin
            case (phase)
                PH_LOAD: begin
                    if (in_take) begin
                        in_cnt <= in_cnt + 1'b1;
                    end
                    if (ps_take) begin
                        ps_cnt <= ps_cnt + 1'b1;
                    end
                    // first vector of a job
                    if (in_take || ps_take) begin
                        drained <= 1'b0;
                    end
                    // last vector taken, start the grid next cycle
                    if (in_done && ps_done) begin
                        phase  <= PH_COMPUTE;
                        step   <= '0;
                        in_cnt <= '0;
                        ps_cnt <= '0;
                    end
                end
                PH_COMPUTE: begin
                    if (step == STEP_LAST) begin
                        phase <= PH_OUTPUT;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                PH_OUTPUT: begin
                    // one result row per cycle
                    if (step == ROW_LAST) begin
                        phase   <= PH_LOAD;
                        step    <= '0;
                        drained <= 1'b1;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: begin
                    phase <= PH_LOAD;
                    step  <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/sysarr_ctrl_pkg.sv */
`default_nettype none

// sequencing side of the array
package sysarr_ctrl_pkg;

    // job phases of the control unit
    typedef enum logic [1:0] {
        PH_LOAD    = 2'd0,
        PH_COMPUTE = 2'd1,
        PH_OUTPUT  = 2'd2
    } phase_t;

    // bits for an index 0..n-1, at least one
    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // step counter holds 0..3n-1
    // so the last capture bound still fits
    function automatic int step_w(input int n);
        return idx_w(3 * n);
    endfunction

endpackage

`default_nettype wire

/* hw/sysarr_mac.sv */
`timescale 1ns/1ps
`default_nettype none

// one grid cell
// weight stays put, inputs move right, sums move down
module sysarr_mac
    import sysarr_num_pkg::*;
(
    input  logic   clk,
    input  logic   nRST,
    input  logic   weight_load,
    input  word_t  weight_in,
    input  logic   enable,
    input  word_t  in_value,
    input  word_t  in_accumulate,
    output word_t  in_pass,
    output word_t  out_accumulate
);

    word_t weight;
    word_t next_acc;

    // stationary weight, reused across jobs
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            weight <= '0;
        end else if (weight_load) begin
            weight <= weight_in;
        end
    end

    // sum from above plus this cell's product
    assign next_acc = mac_step(in_accumulate, in_value, weight);

    // one hop per cycle in both directions
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            in_pass        <= '0;
            out_accumulate <= '0;
        end else if (enable) begin
            in_pass        <= in_value;
            out_accumulate <= next_acc;
        end
    end

endmodule

`default_nettype wire

/* hw/sysarr_num_pkg.sv */
`default_nettype none

// arithmetic side of the array
package sysarr_num_pkg;

    // one data word, also the accumulator width
    localparam int WORD_W = 16;

    // weights, inputs, partials, sums and results all share this type
    typedef logic signed [WORD_W-1:0] word_t;

    // one multiply-accumulate step
    // product and sum both wrap to the word width
    function automatic word_t mac_step(input word_t acc, input word_t a, input word_t w);
        word_t prod;
        prod = word_t'(a * w);
        return word_t'(acc + prod);
    endfunction

endpackage

`default_nettype wire

/* hw/sysarr_result_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// partial adders on the bottom edge and the result store
module sysarr_result_buffer
    import sysarr_num_pkg::*;
    import sysarr_ctrl_pkg::*;
#(
    parameter int N = 4
) (
    input  logic                 clk,
    input  logic                 nRST,
    // indexed by column, not host word order
    input  word_t [N-1:0]        col_sums,
    input  word_t [N-1:0]        partials,
    input  logic [N-1:0]         capture,
    input  logic [idx_w(N)-1:0]  row_out,
    // host order, word 0 at the top index
    output word_t [N-1:0]        array_output
);

    localparam int IW = idx_w(N);
    localparam logic [IW-1:0] SLOT_LAST = IW'(N - 1);

    // column sum plus partial, wraps like the grid
    word_t [N-1:0] sums;
    // results[n][r] holds row r of column n
    word_t [N-1:0] results [N];
    // next row slot per column
    logic [IW-1:0] slot [N];

    genvar n;
    generate
        for (n = 0; n < N; n++) begin : g_col
            assign sums[n] = col_sums[n] + partials[n];

            always_ff @(posedge clk, negedge nRST) begin
                if (!nRST) begin
                    slot[n]    <= '0;
                    results[n] <= '0;
                end else if (capture[n]) begin
                    results[n][slot[n]] <= sums[n];
                    // wraps after row N-1
                    // a new job starts at row 0
                    slot[n] <= (slot[n] == SLOT_LAST) ? '0 : slot[n] + 1'b1;
                end
            end

            // selected row, column n lands at word n
            assign array_output[N-1-n] = results[n][row_out];
        end
    endgenerate

endmodule

`default_nettype wire

/* hw/sysarr_row_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// parallel load, one word out per shift
// feeds a grid row or a partial column
module sysarr_row_fifo
    import sysarr_num_pkg::*;
#(
    parameter int N = 4
) (
    input  logic              clk,
    input  logic              nRST,
    input  logic              load,
    input  logic              shift,
    input  word_t [N-1:0]     load_values,
    output word_t             out
);

    // word 0 sits at the top index
    word_t [N-1:0] words;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            words <= '0;
        end else if (load) begin
            // whole vector at once
            words <= load_values;
        end else if (shift) begin
            // next word moves up, zero fills from the bottom
            words <= {words[N-2:0], {WORD_W{1'b0}}};
        end
    end

    // head of the register
    // zero once the vector has drained out
    assign out = words[N-1];

endmodule

`default_nettype wire

/* hw/systolic_array.sv */
`timescale 1ns/1ps
`default_nettype none

// weight-stationary array, C = A*W + P
module systolic_array
    import sysarr_num_pkg::*;
    import sysarr_ctrl_pkg::*;
#(
    parameter int N = 4
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 weight_en,
    input  logic                 input_en,
    input  logic                 partial_en,
    input  logic                 row_in_en,
    input  logic                 row_ps_en,
    input  word_t [N-1:0]        array_in,
    input  word_t [N-1:0]        array_in_partials,
    output logic                 fifo_has_space,
    output logic                 drained,
    output logic                 out_en,
    output logic [idx_w(N)-1:0]  row_out,
    output word_t [N-1:0]        array_output
);

    logic [N-1:0] weight_load;
    logic [N-1:0] input_load;
    logic [N-1:0] partials_load;
    logic [N-1:0] in_fifo_shift;
    logic [N-1:0] ps_fifo_shift;
    logic [N-1:0] capture;
    logic mac_enable;

    // fifo heads, by row and by column
    word_t in_head [N];
    word_t [N-1:0] ps_head;
    // grid nets, [row][column]
    word_t cell_in [N][N];
    word_t cell_acc_in [N][N];
    word_t cell_pass [N][N];
    word_t cell_acc [N][N];
    word_t [N-1:0] col_sums;

    sysarr_control_unit #(.N(N)) u_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .weight_en      (weight_en),
        .input_en       (input_en),
        .partial_en     (partial_en),
        .row_in_en      (row_in_en),
        .row_ps_en      (row_ps_en),
        .fifo_has_space (fifo_has_space),
        .drained        (drained),
        .weight_load    (weight_load),
        .input_load     (input_load),
        .partials_load  (partials_load),
        .in_fifo_shift  (in_fifo_shift),
        .ps_fifo_shift  (ps_fifo_shift),
        .mac_enable     (mac_enable),
        .capture        (capture),
        .out_en         (out_en),
        .row_out        (row_out)
    );

    genvar m, n;
    generate
        for (m = 0; m < N; m++) begin : g_row
            // input vector m is column m of A
            sysarr_row_fifo #(.N(N)) u_in_fifo (
                .clk         (clk),
                .nRST        (nRST),
                .load        (input_load[m]),
                .shift       (in_fifo_shift[m]),
                .load_values (array_in),
                .out         (in_head[m])
            );

            for (n = 0; n < N; n++) begin : g_cell
                // left edge from the fifo, else from the left neighbour
                if (n == 0) begin : g_left
                    assign cell_in[m][n] = in_head[m];
                end else begin : g_fwd
                    assign cell_in[m][n] = cell_pass[m][n-1];
                end
                // top edge starts every column at zero
                if (m == 0) begin : g_top
                    assign cell_acc_in[m][n] = '0;
                end else begin : g_down
                    assign cell_acc_in[m][n] = cell_acc[m-1][n];
                end

                // weight row m, word n
                sysarr_mac u_mac (
                    .clk            (clk),
                    .nRST           (nRST),
                    .weight_load    (weight_load[m]),
                    .weight_in      (array_in[N-1-n]),
                    .enable         (mac_enable),
                    .in_value       (cell_in[m][n]),
                    .in_accumulate  (cell_acc_in[m][n]),
                    .in_pass        (cell_pass[m][n]),
                    .out_accumulate (cell_acc[m][n])
                );
            end
        end

        for (n = 0; n < N; n++) begin : g_out_col
            // partial vector n is column n of P
            sysarr_row_fifo #(.N(N)) u_ps_fifo (
                .clk         (clk),
                .nRST        (nRST),
                .load        (partials_load[n]),
                .shift       (ps_fifo_shift[n]),
                .load_values (array_in_partials),
                .out         (ps_head[n])
            );
            // bottom row sums
            assign col_sums[n] = cell_acc[N-1][n];
        end
    endgenerate

    sysarr_result_buffer #(.N(N)) u_results (
        .clk          (clk),
        .nRST         (nRST),
        .col_sums     (col_sums),
        .partials     (ps_head),
        .capture      (capture),
        .row_out      (row_out),
        .array_output (array_output)
    );

endmodule

`default_nettype wire

/* include/sysarr_tb_model.svh */
`ifndef SYSARR_TB_MODEL_SVH
`define SYSARR_TB_MODEL_SVH

// matrix model of one job
// needs N, word_t and vec_t from the including module

// weights stay until the next reload
word_t w_mat [N][N];
// A and P of the job in flight
word_t a_mat [N][N];
word_t p_mat [N][N];

// fresh W from the seed
function automatic void gen_weights(inout integer s);
    for (int m = 0; m < N; m++) begin
        for (int n = 0; n < N; n++) begin
            w_mat[m][n] = word_t'($random(s));
        end
    end
endfunction

// fresh A and P for the next job
function automatic void gen_job(inout integer s);
    for (int r = 0; r < N; r++) begin
        for (int c = 0; c < N; c++) begin
            a_mat[r][c] = word_t'($random(s));
            p_mat[r][c] = word_t'($random(s));
        end
    end
endfunction

// weight row m with word n at index N-1-n
function automatic vec_t weight_row(input int m);
    vec_t v;
    for (int n = 0; n < N; n++) begin
        v[N-1-n] = w_mat[m][n];
    end
    return v;
endfunction

// input vector k is column k of A
function automatic vec_t input_vec(input int k);
    vec_t v;
    for (int r = 0; r < N; r++) begin
        v[N-1-r] = a_mat[r][k];
    end
    return v;
endfunction

// partial vector l is column l of P
function automatic vec_t partial_vec(input int l);
    vec_t v;
    for (int r = 0; r < N; r++) begin
        v[N-1-r] = p_mat[r][l];
    end
    return v;
endfunction

// C[r][n] = P[r][n] + sum of A[r][m]*W[m][n]
// summed in 32 bits and cut to the low 16
function automatic vec_t expected_row(input int r);
    vec_t v;
    int sum;
    for (int n = 0; n < N; n++) begin
        sum = int'(p_mat[r][n]);
        for (int m = 0; m < N; m++) begin
            sum = sum + int'(a_mat[r][m]) * int'(w_mat[m][n]);
        end
        v[N-1-n] = word_t'(sum);
    end
    return v;
endfunction

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the systolic array testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module systolic_array_tb \
    --Mdir obj_dir -o systolic_array_tb

# a failing run exits nonzero, the log search below decides the result
./obj_dir/systolic_array_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi

echo "simulation passed"

/* vlog.f */
hw/sysarr_num_pkg.sv
hw/sysarr_ctrl_pkg.sv
hw/sysarr_row_fifo.sv
hw/sysarr_mac.sv
hw/sysarr_control_unit.sv
hw/sysarr_result_buffer.sv
hw/systolic_array.sv
bench/systolic_array_tb.sv
